// ==== design/sclk_timer.sv ====
// ##############################
// SCLK generator, runs only while run is high
// Edge pulses are registered together with the SCLK phase
// ##############################
`timescale 1ns/1ps
`default_nettype none

module sclk_timer
    import spi_pkg::*;
(
    input wire logic clock,
    input wire logic reset,
    input wire logic run,
    input wire divider_t divider,
    input wire length_t length,
    input wire logic sclk_idle_high,
    output logic sclk,
    output logic lead_edge,
    output logic trail_edge,
    output logic last_edge
);

    // Counts system clocks inside one SCLK half period
    divider_t half_count;
    // Counts SCLK edges of the current transfer, up to 64
    logic [6:0] edge_count;
    logic [6:0] edge_total;
    // Zero at the idle level, one at the active level
    logic phase;

    // Two edges per bit
    assign edge_total = 7'({length, 1'b0}) + 7'd2;

    // The idle level only flips the polarity, so the phase logic stays mode free
    assign sclk = phase ^ sclk_idle_high;

    always_ff @(posedge clock) begin
        if (!reset || !run) begin
            half_count <= '0;
            edge_count <= '0;
            phase <= 1'b0;
            lead_edge <= 1'b0;
            trail_edge <= 1'b0;
            last_edge <= 1'b0;
        end else begin
            lead_edge <= 1'b0;
            trail_edge <= 1'b0;
            last_edge <= 1'b0;
            // Once all edges are out SCLK stays idle until run drops
            if (edge_count != edge_total) begin
                if (half_count == divider) begin
                    half_count <= '0;
                    phase <= ~phase;
                    edge_count <= edge_count + 7'd1;
                    // Leaving the idle level is the leading edge
                    lead_edge <= ~phase;
                    trail_edge <= phase;
                    last_edge <= (edge_count + 7'd1 == edge_total);
                end else begin
                    half_count <= half_count + 3'd1;
                end
            end
        end
    end

    // The sequencer holds run until it has seen the last edge
    last_edge_in_run: assert property (@(posedge clock) disable iff (!reset)
        last_edge |-> run);

endmodule

`default_nettype wire

// ==== design/spi_master.sv ====
// ##############################
// SPI master with one SCLK and SS shared by N_CHANNELS lanes
// DATA_WIDTH up to 32, cfg and tx_data are taken with start
// ##############################
`timescale 1ns/1ps
`default_nettype none

module spi_master
    import spi_pkg::*;
#(
    parameter int N_CHANNELS = 3,
    parameter int DATA_WIDTH = 32
) (
    input wire logic clock,
    input wire logic reset,
    input wire spi_config_t cfg,
    input wire logic start,
    input wire logic [N_CHANNELS-1:0][DATA_WIDTH-1:0] tx_data,
    input wire logic [N_CHANNELS-1:0] miso,
    output logic sclk,
    output logic ss,
    output logic [N_CHANNELS-1:0] mosi,
    output logic [N_CHANNELS-1:0][DATA_WIDTH-1:0] rx_data,
    output logic busy,
    output logic done
);

    spi_config_t cur_cfg;
    logic run;
    logic load;
    logic sample;
    logic shift;
    logic lead_edge;
    logic trail_edge;
    logic last_edge;

    spi_sequencer i_sequencer (
        .clock(clock),
        .reset(reset),
        .cfg(cfg),
        .start(start),
        .lead_edge(lead_edge),
        .trail_edge(trail_edge),
        .last_edge(last_edge),
        .run(run),
        .cur_cfg(cur_cfg),
        .load(load),
        .sample(sample),
        .shift(shift),
        .ss(ss),
        .busy(busy),
        .done(done)
    );

    sclk_timer i_timer (
        .clock(clock),
        .reset(reset),
        .run(run),
        .divider(cur_cfg.divider),
        .length(cur_cfg.length),
        .sclk_idle_high(cur_cfg.sclk_idle_high),
        .sclk(sclk),
        .lead_edge(lead_edge),
        .trail_edge(trail_edge),
        .last_edge(last_edge)
    );

    // All lanes share the strobes, only the serial data differs
    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_lane
        spi_shift_register #(
            .DATA_WIDTH(DATA_WIDTH)
        ) i_lane (
            .clock(clock),
            .reset(reset),
            .load(load),
            .sample(sample),
            .shift(shift),
            .msb_first(cur_cfg.msb_first),
            .length(cur_cfg.length),
            .tx_word(tx_data[i]),
            .miso(miso[i]),
            .mosi(mosi[i]),
            .rx_word(rx_data[i])
        );
    end

endmodule

`default_nettype wire

// ==== design/spi_pkg.sv ====
// ##############################
// Widths and configuration shared by the SPI master and its testbench
// A transfer carries at most 32 bits per lane
// ##############################
`default_nettype none

package spi_pkg;

    // SCLK half period is this value plus one system clocks
    typedef logic [2:0] divider_t;

    // Bits per transfer is this value plus one
    typedef logic [4:0] length_t;

    // System clocks between slave select assertion and the start of shifting
    typedef logic [7:0] delay_t;

    // Configuration of one transfer, sampled by the sequencer when start is taken
    typedef struct packed {
        divider_t divider;
        length_t length;
        delay_t ss_delay;
        // First bit on the wire is bit length when set, bit 0 otherwise
        logic msb_first;
        logic ss_active_high;
        logic sclk_idle_high;
        // Clear samples on the leading SCLK edge, set samples on the trailing one
        logic late_latch;
    } spi_config_t;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        SHIFT,
        HOLD
    } seq_state_t;

endpackage

`default_nettype wire

// ==== design/spi_sequencer.sv ====
// ##############################
// Transfer control for all lanes, a start while busy is dropped
// Configuration is frozen from the accepting edge until done
// ##############################
`timescale 1ns/1ps
`default_nettype none

module spi_sequencer
    import spi_pkg::*;
(
    input wire logic clock,
    input wire logic reset,
    input wire spi_config_t cfg,
    input wire logic start,
    input wire logic lead_edge,
    input wire logic trail_edge,
    input wire logic last_edge,
    output logic run,
    output spi_config_t cur_cfg,
    output logic load,
    output logic sample,
    output logic shift,
    output logic ss,
    output logic busy,
    output logic done
);

    seq_state_t state;
    // Shared down-counter for the setup delay and the hold time
    delay_t count;
    // Set after the first leading edge of a transfer
    logic lead_seen;

    assign load = start && (state == IDLE);
    assign busy = (state != IDLE);
    assign run = (state == SHIFT);

    // Latching on the leading edge leaves the trailing edge for the shift
    // Latching on the trailing edge shifts on every leading edge but the first,
    // because the first bit is already on MOSI from load onward
    assign sample = cur_cfg.late_latch ? trail_edge : lead_edge;
    assign shift = cur_cfg.late_latch ? (lead_edge && lead_seen) : trail_edge;

    // Follows cfg while idle, so the last load is the accepting edge
    // This also keeps the SCLK idle level tracking cfg between transfers
    always_ff @(posedge clock) begin
        if (!reset || state == IDLE) begin
            cur_cfg <= cfg;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= IDLE;
            count <= '0;
            ss <= 1'b0;
            done <= 1'b0;
            lead_seen <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        // Live cfg here, cur_cfg is loaded by the same edge
                        ss <= cfg.ss_active_high;
                        lead_seen <= 1'b0;
                        if (cfg.ss_delay == '0) begin
                            state <= SHIFT;
                        end else begin
                            state <= SETUP;
                            count <= cfg.ss_delay - 8'd1;
                        end
                    end
                end
                SETUP: begin
                    if (count == '0) begin
                        state <= SHIFT;
                    end else begin
                        count <= count - 8'd1;
                    end
                end
                SHIFT: begin
                    if (lead_edge) begin
                        lead_seen <= 1'b1;
                    end
                    // Hold one more half period after SCLK is back at idle
                    if (last_edge) begin
                        state <= HOLD;
                        count <= delay_t'(cur_cfg.divider);
                    end
                end
                HOLD: begin
                    if (count == '0) begin
                        state <= IDLE;
                        done <= 1'b1;
                        ss <= ~cur_cfg.ss_active_high;
                    end else begin
                        count <= count - 8'd1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    done_one_cycle: assert property (@(posedge clock) disable iff (!reset)
        done |=> !done);

    ss_active_in_shift: assert property (@(posedge clock) disable iff (!reset)
        (state == SHIFT) |-> (ss == cur_cfg.ss_active_high));

    // A start during a transfer must leave its configuration alone
    start_only_in_idle: assert property (@(posedge clock) disable iff (!reset)
        (start && state != IDLE) |=> $stable(cur_cfg));

endmodule

`default_nettype wire

// ==== design/spi_shift_register.sv ====
// ##############################
// One lane, bits above length are ignored on transmit and zero on receive
// msb_first and length must hold from the cycle after load to the last sample
// ##############################
`timescale 1ns/1ps
`default_nettype none

module spi_shift_register
    import spi_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input wire logic clock,
    input wire logic reset,
    input wire logic load,
    input wire logic sample,
    input wire logic shift,
    input wire logic msb_first,
    input wire length_t length,
    input wire logic [DATA_WIDTH-1:0] tx_word,
    input wire logic miso,
    output logic mosi,
    output logic [DATA_WIDTH-1:0] rx_word
);

    logic [DATA_WIDTH-1:0] tx_reg;
    logic [DATA_WIDTH-1:0] rx_shift;
    logic [DATA_WIDTH-1:0] rx_next;
    // Bits already shifted out, saturating at length
    length_t tx_count;
    // Bits already sampled, one wider to count a full 32 bit word
    logic [5:0] rx_count;
    length_t tx_index;
    length_t rx_index;

    // Both directions walk down from bit length or up from bit 0
    assign tx_index = msb_first ? length - tx_count : tx_count;
    assign rx_index = msb_first ? length - rx_count[4:0] : rx_count[4:0];

    assign mosi = (int'(tx_index) < DATA_WIDTH) ? tx_reg[tx_index] : 1'b0;

    // Placing each bit at its final position keeps the word right-aligned
    always_comb begin
        rx_next = rx_shift;
        if (int'(rx_index) < DATA_WIDTH) begin
            rx_next[rx_index] = miso;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset || load) begin
            tx_count <= '0;
            rx_count <= '0;
        end else begin
            if (shift && tx_count != length) begin
                tx_count <= tx_count + 5'd1;
            end
            if (sample) begin
                rx_count <= rx_count + 6'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            tx_reg <= tx_word;
            rx_shift <= '0;
        end else if (sample) begin
            rx_shift <= rx_next;
        end
        // Final bit goes straight into the output word
        if (!load && sample && rx_count == {1'b0, length}) begin
            rx_word <= rx_next;
        end
    end

    // The timer gives exactly length+1 latching edges per transfer
    sample_count_limit: assert property (@(posedge clock) disable iff (!reset)
        sample |-> (rx_count <= {1'b0, length}));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the SPI master testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

TOP=spi_master_tb
BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module "$TOP" \
        --Mdir "$BUILD_DIR" -f verilog.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tests/clock_gen.sv ====
// ##############################
// Testbench clock and active-low reset
// Reset is released on a falling edge
// ##############################
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock = ~clock;
        end
    end

    // Held for RESET_CYCLES rising edges, then dropped half a period later
    initial begin
        reset <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/spi_master_tb.sv ====
// ##############################
// Testbench for spi_master with three 32 bit lanes and one SPI slave model each
// All random data comes from a fixed-seed LFSR and inputs change on falling edges
// ##############################
`timescale 1ns/1ps
`default_nettype none

module spi_master_tb
    import spi_pkg::*;
();

    localparam int N_CHANNELS = 3;
    localparam int DATA_WIDTH = 32;
    localparam int TRANSFERS = 40;
    localparam int BUSY_TRANSFERS = 8;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RESET_TIMEOUT = 64;
    localparam int WATCH_CYCLES = 12;

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [N_CHANNELS-1:0][DATA_WIDTH-1:0] lanes_t;

    logic clock;
    logic reset;
    spi_config_t cfg;
    logic start;
    lanes_t tx_data;
    logic [N_CHANNELS-1:0] miso;
    logic sclk;
    logic ss;
    logic busy;
    logic done;
    logic [N_CHANNELS-1:0] mosi;
    lanes_t rx_data;

    logic [31:0] lfsr_state;
    int test_checks [1:5];
    int test_errors [1:5];
    logic timed_out;

    clock_gen #(
        .PERIOD_NS(40),
        .RESET_CYCLES(8)
    ) i_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    spi_master #(
        .N_CHANNELS(N_CHANNELS),
        .DATA_WIDTH(DATA_WIDTH)
    ) i_dut (
        .clock(clock),
        .reset(reset),
        .cfg(cfg),
        .start(start),
        .tx_data(tx_data),
        .miso(miso),
        .sclk(sclk),
        .ss(ss),
        .mosi(mosi),
        .rx_data(rx_data),
        .busy(busy),
        .done(done)
    );

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic feedback;
        int k;
        value = '0;
        for (k = 0; k < n; k++) begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Word bit that travels as the k-th bit on the wire
    function automatic int wire_position(input spi_config_t c, input int k);
        if (c.msb_first) begin
            return int'(c.length) - k;
        end
        return k;
    endfunction

    // MISO of every slave while it presents its k-th bit and zero past the last one
    function automatic logic [N_CHANNELS-1:0] slave_bits(input spi_config_t c,
                                                         input lanes_t words, input int k);
        logic [N_CHANNELS-1:0] bits;
        int ch;
        bits = '0;
        if (k <= int'(c.length)) begin
            for (ch = 0; ch < N_CHANNELS; ch++) begin
                bits[ch] = words[ch][wire_position(c, k)];
            end
        end
        return bits;
    endfunction

    function automatic spi_config_t random_config(input int t);
        spi_config_t c;
        c.divider = divider_t'(take_bits(3));
        c.length = length_t'(take_bits(5));
        // Short delays half of the time so zero and one show up often
        if (take_bits(1) != 0) begin
            c.ss_delay = delay_t'(take_bits(8));
        end else begin
            c.ss_delay = delay_t'(take_bits(2));
        end
        c.msb_first = 1'(take_bits(1));
        c.ss_active_high = 1'(take_bits(1));
        c.sclk_idle_high = 1'(take_bits(1));
        c.late_latch = 1'(take_bits(1));
        // The first two transfers cover the longest and the shortest word
        if (t == 0) begin
            c.length = 5'd31;
        end
        if (t == 1) begin
            c.length = '0;
            c.divider = '0;
            c.ss_delay = '0;
        end
        return c;
    endfunction

    task automatic check_value(input int test_id, input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        test_checks[test_id]++;
        assert (got === expected) else begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, expected);
            test_errors[test_id]++;
        end
    endtask

    task automatic report_test(input int id, input string name);
        $display("test %0d %s: %0d checks, %0d errors", id, name, test_checks[id],
                 test_errors[id]);
    endtask

    // Idle outputs while reset is low and for a few cycles after it is released
    task automatic check_reset();
        int n;
        n = 0;
        while (reset !== 1'b1 && n < RESET_TIMEOUT) begin
            @(negedge clock);
            n++;
            check_value(1, "done", 64'(done), 64'd0);
            check_value(1, "busy", 64'(busy), 64'd0);
            check_value(1, "ss", 64'(ss), 64'd0);
            check_value(1, "sclk", 64'(sclk), 64'(cfg.sclk_idle_high));
        end
        if (reset !== 1'b1) begin
            $display("Reset was never released within %0d cycles", RESET_TIMEOUT);
            test_errors[1]++;
            timed_out = 1'b1;
        end else begin
            for (n = 0; n < 4; n++) begin
                @(negedge clock);
                check_value(1, "done", 64'(done), 64'd0);
                check_value(1, "busy", 64'(busy), 64'd0);
                check_value(1, "ss", 64'(ss), 64'd0);
                check_value(1, "sclk", 64'(sclk), 64'(cfg.sclk_idle_high));
            end
        end
    endtask

    // One transfer with slave models on every lane that starts and ends on a falling edge
    task automatic run_transfer(input spi_config_t c, input logic disturb, input int rx_id,
                                input int tx_id, input int lvl_id);
        lanes_t tx_words;
        lanes_t slave_words;
        lanes_t captured;
        word_t mask;
        int nbits;
        int rel;
        int edges;
        int first_rel;
        int bit_in;
        int bit_out;
        int ch;
        int k;
        logic sclk_prev;
        logic latch;
        logic done_seen;
        nbits = int'(c.length) + 1;
        mask = word_t'((64'd1 << nbits) - 64'd1);
        for (ch = 0; ch < N_CHANNELS; ch++) begin
            tx_words[ch] = take_bits(DATA_WIDTH);
            slave_words[ch] = take_bits(DATA_WIDTH);
        end
        captured = '0;
        // The SCLK idle level follows cfg a cycle late, so cfg settles before start
        cfg = c;
        tx_data = tx_words;
        @(negedge clock);
        @(negedge clock);
        check_value(lvl_id, "sclk", 64'(sclk), 64'(c.sclk_idle_high));
        check_value(lvl_id, "busy", 64'(busy), 64'd0);
        // First slave bit must be on MISO before the first latching edge
        miso = slave_bits(c, slave_words, 0);
        start = 1'b1;
        sclk_prev = sclk;
        rel = 0;
        edges = 0;
        first_rel = -1;
        bit_in = 0;
        bit_out = 0;
        done_seen = 1'b0;
        while (!done_seen && rel < TIMEOUT_CYCLES) begin
            @(negedge clock);
            rel++;
            start = 1'b0;
            cfg = c;
            if (done === 1'b1) begin
                done_seen = 1'b1;
            end else begin
                check_value(lvl_id, "ss", 64'(ss), 64'(c.ss_active_high));
                check_value(lvl_id, "busy", 64'(busy), 64'd1);
            end
            if (sclk !== sclk_prev) begin
                edges++;
                if (edges == 1) begin
                    first_rel = rel;
                end
                // Leaving the idle level is a leading edge
                latch = (sclk != c.sclk_idle_high) ^ c.late_latch;
                if (latch) begin
                    if (bit_in < nbits) begin
                        for (ch = 0; ch < N_CHANNELS; ch++) begin
                            captured[ch][wire_position(c, bit_in)] = mosi[ch];
                        end
                    end
                    bit_in++;
                end else if (!(c.late_latch && edges == 1)) begin
                    // Slave shifts on the other edge except on the first leading edge
                    bit_out++;
                    miso = slave_bits(c, slave_words, bit_out);
                end
                if (disturb && edges == 1) begin
                    start = 1'b1;
                    cfg = random_config(99);
                    for (ch = 0; ch < N_CHANNELS; ch++) begin
                        tx_data[ch] = take_bits(DATA_WIDTH);
                    end
                end
            end
            sclk_prev = sclk;
        end
        if (!done_seen) begin
            $display("done did not arrive within %0d cycles of start", TIMEOUT_CYCLES);
            test_errors[lvl_id]++;
            timed_out = 1'b1;
        end else begin
            for (ch = 0; ch < N_CHANNELS; ch++) begin
                check_value(rx_id, $sformatf("rx_data[%0d]", ch), 64'(rx_data[ch]),
                            64'(slave_words[ch] & mask));
                check_value(tx_id, $sformatf("mosi[%0d] word", ch), 64'(captured[ch]),
                            64'(tx_words[ch] & mask));
            end
            check_value(lvl_id, "sclk edge count", 64'(edges), 64'(2 * nbits));
            check_value(lvl_id, "first sclk edge cycle", 64'(first_rel),
                        64'(int'(c.ss_delay) + int'(c.divider) + 2));
            check_value(lvl_id, "done cycle", 64'(rel),
                        64'(int'(c.ss_delay) + (2 * nbits + 1) * (int'(c.divider) + 1) + 2));
            check_value(lvl_id, "ss", 64'(ss), 64'(!c.ss_active_high));
            check_value(lvl_id, "busy", 64'(busy), 64'd0);
            // Bus stays quiet after done, so a start seen while busy left no trace
            for (k = 0; k < WATCH_CYCLES; k++) begin
                @(negedge clock);
                check_value(lvl_id, "done", 64'(done), 64'd0);
                check_value(lvl_id, "busy", 64'(busy), 64'd0);
                check_value(lvl_id, "sclk", 64'(sclk), 64'(c.sclk_idle_high));
                check_value(lvl_id, "ss", 64'(ss), 64'(!c.ss_active_high));
            end
            for (ch = 0; ch < N_CHANNELS; ch++) begin
                check_value(rx_id, $sformatf("rx_data[%0d]", ch), 64'(rx_data[ch]),
                            64'(slave_words[ch] & mask));
            end
        end
    endtask

    initial begin
        int t;
        int total_checks;
        int total_errors;
        lfsr_state = 32'h9e04_8c62;
        timed_out = 1'b0;
        cfg = '{divider: 3'd1, length: 5'd7, ss_delay: 8'd2, msb_first: 1'b1,
                ss_active_high: 1'b1, sclk_idle_high: 1'b1, late_latch: 1'b0};
        start = 1'b0;
        tx_data = '0;
        miso = '0;
        for (t = 1; t <= 5; t++) begin
            test_checks[t] = 0;
            test_errors[t] = 0;
        end
        check_reset();
        report_test(1, "reset state");
        t = 0;
        while (t < TRANSFERS && !timed_out) begin
            run_transfer(random_config(t), 1'b0, 2, 3, 4);
            t++;
        end
        report_test(2, "random receive");
        report_test(3, "random transmit");
        report_test(4, "signal levels and timing");
        t = 0;
        while (t < BUSY_TRANSFERS && !timed_out) begin
            run_transfer(random_config(t + 2), 1'b1, 5, 5, 5);
            t++;
        end
        report_test(5, "start while busy");
        total_checks = 0;
        total_errors = 0;
        for (t = 1; t <= 5; t++) begin
            total_checks += test_checks[t];
            total_errors += test_errors[t];
        end
        $display("checks %0d, errors %0d", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/spi_pkg.sv
design/sclk_timer.sv
design/spi_sequencer.sv
design/spi_shift_register.sv
design/spi_master.sv
tests/clock_gen.sv
tests/spi_master_tb.sv
